// File: Makefile
# Verilator simulation of the vector-magnitude unit
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= vec_mag_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST OK

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass text
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
rtl/vec_mag_pkg.sv
rtl/sum_of_squares.sv
rtl/isqrt_stage.sv
rtl/isqrt_pipe.sv
rtl/vec_mag_top.sv
tb/tb_clk_gen.sv
tb/vec_mag_assert.sv
tb/vec_mag_tb.sv

// File: rtl/isqrt_pipe.sv
`timescale 1ns/100ps

// Eight restoring root stages, one root bit per clock, MSB first.
// Together with sum_of_squares the path from in_valid to out_valid
// is LATENCY clocks.
module isqrt_pipe
    import vec_mag_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sq_valid,    // Strobe from the square stage
    input  sumsq_t sumsq,
    output logic   out_valid,
    output root_t  mag,         // floor(sqrt(sumsq))
    output logic   exact        // sumsq was a perfect square
);

    // Index k is the input of stage k, index ROOT_W the pipe output
    logic   valid_q [0:ROOT_W];
    sumsq_t rad_q   [0:ROOT_W];
    rem_t   rem_q   [0:ROOT_W];
    root_t  root_q  [0:ROOT_W];

    // Fresh vector starts with empty remainder and root
    assign valid_q[0] = sq_valid;
    assign rad_q[0]   = sumsq;
    assign rem_q[0]   = '0;
    assign root_q[0]  = '0;

    for (genvar k = 0; k < ROOT_W; k++) begin : g_stage
        isqrt_stage u_isqrt_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .valid_in  (valid_q[k]),
            .rad_in    (rad_q[k]),
            .rem_in    (rem_q[k]),
            .root_in   (root_q[k]),
            .valid_out (valid_q[k+1]),
            .rad_out   (rad_q[k+1]),
            .rem_out   (rem_q[k+1]),
            .root_out  (root_q[k+1])
        );
    end

    assign out_valid = valid_q[ROOT_W];
    assign mag       = root_q[ROOT_W];

    // Nothing left over means root squared equals the sum
    assign exact = (rem_q[ROOT_W] == '0);

endmodule

// File: rtl/isqrt_stage.sv
`timescale 1ns/100ps

module isqrt_stage
    import vec_mag_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   valid_in,
    input  sumsq_t rad_in,      // Unconsumed radicand bits, top aligned
    input  rem_t   rem_in,
    input  root_t  root_in,     // Root bits decided so far, right aligned
    output logic   valid_out,
    output sumsq_t rad_out,
    output rem_t   rem_out,
    output root_t  root_out
);

    rem_t  rem_shift;   // Remainder with the next bit pair brought down
    rem_t  trial;       // 4 * root + 1
    rem_t  rem_diff;
    logic  root_bit;    // Root digit decided here
    rem_t  rem_next;
    root_t root_next;

    // Incoming remainder never exceeds 2 * root, so its top two bits are zero
    assign rem_shift = {rem_in[REM_W-3:0], rad_in[SUMSQ_W-1 -: 2]};

    assign trial = {root_in, 2'b01};

    assign rem_diff = rem_shift - trial;

    // Restoring step, keep the old remainder on a zero digit
    assign root_bit  = (rem_shift >= trial);
    assign rem_next  = root_bit ? rem_diff : rem_shift;
    assign root_next = {root_in[ROOT_W-2:0], root_bit};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;   // Valid moves every clock
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rad_out  <= '0;
            rem_out  <= '0;
            root_out <= '0;
        end else if (valid_in) begin
            rad_out  <= {rad_in[SUMSQ_W-3:0], 2'b00};   // Next bit pair to the top
            rem_out  <= rem_next;
            root_out <= root_next;
        end
    end

endmodule

// File: rtl/sum_of_squares.sv
`timescale 1ns/100ps

module sum_of_squares
    import vec_mag_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,    // One vector per strobe
    input  coord_t x,
    input  coord_t y,
    output logic   sq_valid,    // in_valid one clock later
    output sumsq_t sumsq        // Saturated x*x + y*y
);

    sumsq_t           x_sq;
    sumsq_t           y_sq;
    logic [SUMSQ_W:0] sum_full;   // Extra bit holds the carry
    sumsq_t           sum_sat;

    // Products are full width, 255*255 still fits in 16 bits
    assign x_sq = SUMSQ_W'(x) * SUMSQ_W'(x);
    assign y_sq = SUMSQ_W'(y) * SUMSQ_W'(y);

    assign sum_full = {1'b0, x_sq} + {1'b0, y_sq};

    // Above 65535 the root pins at 255
    assign sum_sat = sum_full[SUMSQ_W] ? SUMSQ_MAX : sum_full[SUMSQ_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_valid <= 1'b0;
            sumsq    <= '0;
        end else begin
            sq_valid <= in_valid;
            if (in_valid) begin
                sumsq <= sum_sat;   // Hold last sum between strobes
            end
        end
    end

endmodule

// File: rtl/vec_mag_pkg.sv
package vec_mag_pkg;

    // Widths of the datapath
    localparam int COORD_W = 8;              // One unsigned coordinate
    localparam int SUMSQ_W = 2 * COORD_W;    // Sum of squares after saturation
    localparam int ROOT_W  = SUMSQ_W / 2;    // Root bits, one root stage each
    localparam int REM_W   = ROOT_W + 2;     // Headroom for the trial subtract

    // One square stage in front of the root stages
    localparam int LATENCY = 1 + ROOT_W;

    typedef logic [COORD_W-1:0] coord_t;     // x or y
    typedef logic [SUMSQ_W-1:0] sumsq_t;     // Sum of squares, radicand
    typedef logic [ROOT_W-1:0]  root_t;      // Partial or final root
    typedef logic [REM_W-1:0]   rem_t;       // Running remainder

    // Clamp value when x*x + y*y needs a seventeenth bit
    localparam sumsq_t SUMSQ_MAX = '1;

endpackage

// File: rtl/vec_mag_top.sv
`timescale 1ns/100ps

module vec_mag_top
    import vec_mag_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,    // Sample x and y this clock
    input  coord_t x,
    input  coord_t y,
    output logic   out_valid,   // One pulse per accepted vector
    output root_t  mag,         // Integer length of (x, y)
    output logic   exact        // Length is exact, Pythagorean pair
);

    logic   sq_valid;
    sumsq_t sumsq;

    sum_of_squares u_sum_of_squares (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .sq_valid (sq_valid),
        .sumsq    (sumsq)
    );

    isqrt_pipe u_isqrt_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .sq_valid  (sq_valid),
        .sumsq     (sumsq),
        .out_valid (out_valid),
        .mag       (mag),
        .exact     (exact)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;   // 20 ns period
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;   // Released right after the fifth rising edge
    end

endmodule

// File: tb/vec_mag_assert.sv
`timescale 1ns/100ps

module vec_mag_assert
    import vec_mag_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   in_valid,
    input logic   out_valid,
    input root_t  mag,
    input logic   exact,
    input sumsq_t sumsq     // Registered sum inside the top
);

    // No result may leave while the pipe is held in reset
    a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##LATENCY out_valid)
        else $error("out_valid missing LATENCY cycles after in_valid");

    // The sum leaves the square stage ROOT_W clocks before the root is done
    a_mag_bound : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (SUMSQ_W'(mag) * SUMSQ_W'(mag)) <= $past(sumsq, ROOT_W))
        else $error("mag squared exceeds the sum of squares");

    a_exact_equal : assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && exact) |-> (SUMSQ_W'(mag) * SUMSQ_W'(mag)) == $past(sumsq, ROOT_W))
        else $error("exact set but mag squared differs from the sum");

endmodule

bind vec_mag_top vec_mag_assert u_vec_mag_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .mag       (mag),
    .exact     (exact),
    .sumsq     (sumsq)
);

// File: tb/vec_mag_tb.sv
`timescale 1ns/100ps

module vec_mag_tb
    import vec_mag_pkg::*;
();

    localparam int          NUM_RANDOM    = 40;
    localparam int          RESET_TIMEOUT = 20;
    localparam int          DRAIN_TIMEOUT = 4 * LATENCY;
    localparam logic [31:0] SEED          = 32'h610d_af55;

    typedef struct {
        string  name;
        coord_t x;
        coord_t y;
        root_t  mag;
        logic   exact;
    } entry_t;

    typedef struct {
        string name;
        root_t mag;
        logic  exact;
        int    due;     // Cycle count at which out_valid should show
    } expect_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    coord_t  x;
    coord_t  y;
    logic    out_valid;
    root_t   mag;
    logic    exact;
    int      cycle_cnt;
    entry_t  vec_table [$];
    expect_t exp_q [$];

    tb_clk_gen u_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vec_mag_top u_vec_mag_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .x         (x),
        .y         (y),
        .out_valid (out_valid),
        .mag       (mag),
        .exact     (exact)
    );

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(string name, string what, int expected, int actual);
        if (expected != actual) begin
            fail_run($sformatf("ERR %s %s expected %0d actual %0d",
                               name, what, expected, actual));
        end
    endtask

    // Square sum clamped to 16 bits
    function automatic int clamped_sum(int xv, int yv);
        int s;
        s = xv * xv + yv * yv;
        if (s > 65535) begin
            s = 65535;
        end
        return s;
    endfunction

    function automatic int floor_root(int s);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= s) begin
            r++;
        end
        return r;
    endfunction

    task automatic add_entry(string name, coord_t xv, coord_t yv, root_t emag, logic eexact);
        entry_t e;
        e.name  = name;
        e.x     = xv;
        e.y     = yv;
        e.mag   = emag;
        e.exact = eexact;
        vec_table.push_back(e);
    endtask

    task automatic build_table();
        add_entry("zero",         8'd0,   8'd0,   8'd0,   1'b1);
        add_entry("x_axis",       8'd7,   8'd0,   8'd7,   1'b1);
        add_entry("y_axis",       8'd0,   8'd200, 8'd200, 1'b1);
        add_entry("x_max",        8'd255, 8'd0,   8'd255, 1'b1);
        add_entry("pyth_3_4",     8'd3,   8'd4,   8'd5,   1'b1);
        add_entry("pyth_5_12",    8'd5,   8'd12,  8'd13,  1'b1);
        add_entry("pyth_8_15",    8'd8,   8'd15,  8'd17,  1'b1);
        add_entry("pyth_120_160", 8'd120, 8'd160, 8'd200, 1'b1);
        add_entry("unit_diag",    8'd1,   8'd1,   8'd1,   1'b0);
        add_entry("floor_1_2",    8'd1,   8'd2,   8'd2,   1'b0);
        add_entry("diag_10",      8'd10,  8'd10,  8'd14,  1'b0);
        add_entry("diag_180",     8'd180, 8'd180, 8'd254, 1'b0);
        add_entry("diag_181",     8'd181, 8'd181, 8'd255, 1'b0);   // Sum 65522 sits below clamp
        add_entry("sat_182_181",  8'd182, 8'd181, 8'd255, 1'b0);
        add_entry("sat_200",      8'd200, 8'd200, 8'd255, 1'b0);
        add_entry("sat_255",      8'd255, 8'd255, 8'd255, 1'b0);
    endtask

    task automatic drive_vector(string name, coord_t xv, coord_t yv, root_t emag, logic eexact);
        expect_t item;
        @(posedge clk);
        in_valid <= 1'b1;
        x        <= xv;
        y        <= yv;
        item.name  = name;
        item.mag   = emag;
        item.exact = eexact;
        item.due   = cycle_cnt + LATENCY + 1;   // DUT samples on the next edge
        exp_q.push_back(item);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Results are sampled on the falling edge half a cycle after they settle
    always @(negedge clk) begin : monitor
        expect_t item;
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("out_valid pulsed with no vector in flight");
                end else begin
                    item = exp_q.pop_front();
                    check_value(item.name, "mag", int'(item.mag), int'(mag));
                    check_value(item.name, "exact", int'(item.exact), int'(exact));
                    check_value(item.name, "cycle", item.due, cycle_cnt);
                end
            end else if (exp_q.size() != 0 && cycle_cnt > exp_q[0].due) begin
                fail_run($sformatf("no result for %s by cycle %0d",
                                   exp_q[0].name, exp_q[0].due));
            end
        end
    end

    initial begin : stimulus
        int     wait_cnt;
        int     s;
        int     r;
        int     gap;
        coord_t rx;
        coord_t ry;
        in_valid <= 1'b0;
        x        <= '0;
        y        <= '0;
        void'($urandom(SEED));
        build_table();

        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            if (wait_cnt == RESET_TIMEOUT) begin
                fail_run("reset was never released");
            end
            @(posedge clk);
            wait_cnt++;
        end

        // Whole table back to back with one strobe per clock
        foreach (vec_table[i]) begin
            drive_vector(vec_table[i].name, vec_table[i].x, vec_table[i].y,
                         vec_table[i].mag, vec_table[i].exact);
        end
        idle_cycles(3);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rx  = coord_t'($urandom());
            ry  = coord_t'($urandom());
            s   = clamped_sum(int'(rx), int'(ry));
            r   = floor_root(s);
            drive_vector($sformatf("rand_%0d", n), rx, ry, root_t'(r), (r * r == s));
            gap = $urandom_range(3, 0);
            idle_cycles(gap);
        end
        idle_cycles(1);

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end

        // Quiet window in which the monitor flags any stray out_valid
        repeat (2 * LATENCY) @(posedge clk);

        if (exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_run("results still pending after the drain");
        end
    end

endmodule
